// ==== build.f ====
hdl/sar_pkg.sv
hdl/sar_sequencer.sv
hdl/sar_cycle_timer.sv
hdl/sar_search.sv
hdl/sar_lane.sv
hdl/sar_result_collect.sv
hdl/sar_adc_top.sv
test/tb_comp_model.sv
test/tb_sar_adc.sv

// ==== Bender.yml ====
package:
  name: sar_adc

sources:
  - hdl/sar_pkg.sv
  - hdl/sar_sequencer.sv
  - hdl/sar_cycle_timer.sv
  - hdl/sar_search.sv
  - hdl/sar_lane.sv
  - hdl/sar_result_collect.sv
  - hdl/sar_adc_top.sv
  - target: test
    files:
      - test/tb_comp_model.sv
      - test/tb_sar_adc.sv

// ==== test/tb_sar_adc.sv ====
`timescale 1ns/1ps

module tb_sar_adc import sar_pkg::*; ();

   localparam int N_LANES  = 4;
   localparam int WORST    = (83 + 1) + 10 * (23 + 1); // longest conversion
   localparam int CONV_MAX = WORST + N_LANES + 16;    // start, done and drain slack
   localparam int N_CONV   = 12;
   localparam int MAX_CYC  = (3 * (N_CONV * WORST + 100)) / 2;

   logic                           clk = 1'b0;
   logic                           rst_n;
   logic                           cmd_stb;
   sar_cmd_e                       cmd;
   logic [N_LANES-1:0]             lane_mask;
   sar_cfg_t                       cfg;
   logic [N_LANES-1:0]             comp;
   logic [N_LANES-1:0][CODE_W-1:0] dac_code;
   logic [N_LANES-1:0]             sample;
   logic [N_LANES-1:0]             busy;
   logic                           scanning;
   logic                           res_valid;
   sar_result_t                    res;

   logic [N_LANES-1:0][CODE_W-1:0] vin;      // levels seen by the comparators
   logic [N_LANES-1:0]             exp_mask;
   logic [31:0]                    seed = 32'h00ec_b9e0;
   int                             tot_cnt [N_LANES] = '{default: 0};
   int                             base_cnt [N_LANES] = '{default: 0};
   int                             smpl_cnt [N_LANES] = '{default: 0};
   int                             errors = 0;   // wrong values
   int                             fails = 0;    // missing or late responses
   int                             cycles = 0;
   bit                             scan_mode = 1'b0;
   bit                             stopping = 1'b0;
   bit                             quiet = 1'b0;

   always #10 clk = ~clk;

   sar_adc_top #(.N_LANES(N_LANES)) dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_stb   (cmd_stb),
      .cmd       (cmd),
      .lane_mask (lane_mask),
      .cfg       (cfg),
      .comp      (comp),
      .dac_code  (dac_code),
      .sample    (sample),
      .busy      (busy),
      .scanning  (scanning),
      .res_valid (res_valid),
      .res       (res)
   );

   tb_comp_model #(.N_LANES(N_LANES)) u_comp (
      .vin      (vin),
      .dac_code (dac_code),
      .comp     (comp)
   );

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int smpl_len(input logic [1:0] sel);
      case (sel)
         2'd0:    return 35;
         2'd1:    return 47;
         2'd2:    return 59;
         default: return 83;
      endcase
   endfunction

   // exact in 10-bit mode, within 4 LSB in 8-bit mode
   function automatic bit code_ok(input sar_result_t r);
      int d;
      d = int'(r.code) - int'(vin[r.lane]);
      if (r.sar10) return d == 0;
      return (d >= -4) && (d <= 4);
   endfunction

   always @(posedge clk) begin
      if (res_valid) tot_cnt[res.lane] <= tot_cnt[res.lane] + 1;
      for (int i = 0; i < N_LANES; i++) begin
         smpl_cnt[i] <= sample[i] ? smpl_cnt[i] + 1 : 0;
      end
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYC);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      (dut.start == '0 && sample == '0 && busy == '0 && !scanning && !res_valid &&
       dac_code == '0))
   else begin
      errors++;
      $display("ERROR reset state: start=%h sample=%h busy=%h scanning=%h res_valid=%h dac_code=%h",
               dut.start, sample, busy, scanning, res_valid, dac_code);
   end

   a_res_code: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> code_ok(res))
   else begin
      errors++;
      $display("ERROR res.code: got %h exp %h (lane %0d)", res.code, vin[res.lane], res.lane);
   end

   a_res_mode: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (res.sar10 == cfg.sar10))
   else begin
      errors++;
      $display("ERROR res.sar10: got %h exp %h", res.sar10, cfg.sar10);
   end

   a_res_masked: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> exp_mask[res.lane])
   else begin
      errors++;
      $display("ERROR res.lane: got %h outside mask %h", res.lane, exp_mask);
   end

   a_res_once: assert property (@(posedge clk) disable iff (!rst_n)
      (res_valid && !scan_mode) |-> (tot_cnt[res.lane] == base_cnt[res.lane]))
   else begin
      errors++;
      $display("ERROR res.lane: second result from lane %h in one command", res.lane);
   end

   a_quiet: assert property (@(posedge clk) disable iff (!rst_n) quiet |-> !res_valid)
   else begin
      errors++;
      $display("ERROR res_valid: got %h exp 0 after stop", res_valid);
   end

   for (genvar i = 0; i < N_LANES; i++) begin : g_lane_chk
      a_smpl_len: assert property (@(posedge clk) disable iff (!rst_n || stopping)
         $fell(sample[i]) |-> (smpl_cnt[i] == smpl_len(cfg.smpl_sel) + 1))
      else begin
         errors++;
         $display("ERROR sample[%0d] width: got %h exp %h", i, smpl_cnt[i],
                  smpl_len(cfg.smpl_sel) + 1);
      end

      a_dac_hold: assert property (@(posedge clk) disable iff (!rst_n)
         sample[i] |=> (!sample[i] || $stable(dac_code[i])))
      else begin
         errors++;
         $display("ERROR dac_code[%0d]: got %h exp %h while sampling", i, dac_code[i],
                  $past(dac_code[i]));
      end
   end

   task automatic rand_vin();
      for (int i = 0; i < N_LANES; i++) begin
         seed   = lcg(seed);
         vin[i] = seed[25:16];
      end
   endtask

   task automatic rand_mask(output logic [N_LANES-1:0] m);
      seed = lcg(seed);
      m    = seed[19:16];
      if (m == '0) m = 4'h1; // at least one lane
   endtask

   task automatic send_cmd(input sar_cmd_e c, input logic [N_LANES-1:0] m, input sar_cfg_t cf);
      @(negedge clk);
      base_cnt = tot_cnt;
      if (c != CMD_STOP) exp_mask = m;
      cmd_stb   = 1'b1;
      cmd       = c;
      lane_mask = m;
      cfg       = cf;
      @(negedge clk);
      cmd_stb = 1'b0;
      cmd     = CMD_NONE;
   endtask

   task automatic wait_results(input logic [N_LANES-1:0] m, input int need, input int limit);
      int  n;
      bit  ok;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge clk);
         n++;
         ok = 1'b1;
         for (int i = 0; i < N_LANES; i++) begin
            if (m[i] && (tot_cnt[i] - base_cnt[i] < need)) ok = 1'b0;
         end
      end
      assert (ok) else begin
         fails++;
         $display("missing results: mask %h did not deliver %0d each within %0d cycles",
                  m, need, limit);
      end
   endtask

   task automatic run_single(input logic [N_LANES-1:0] m, input sar_cfg_t cf);
      send_cmd(CMD_SINGLE, m, cf);
      wait_results(m, 1, CONV_MAX);
      repeat (N_LANES + 4) @(negedge clk); // stray results trip a_res_once
   endtask

   initial begin
      sar_cfg_t           c;
      logic [N_LANES-1:0] m;
      rst_n     = 1'b0;
      cmd_stb   = 1'b0;
      cmd       = CMD_NONE;
      lane_mask = '0;
      cfg       = '0;
      vin       = '0;
      exp_mask  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      rand_vin();
      vin[0] = 10'd0;    // range ends
      vin[1] = 10'd1023;
      c = '{sar10: 1'b1, smpl_sel: 2'd0, step_slow: 1'b0};
      run_single(4'hF, c); // all lanes finish together

      for (int k = 0; k < 4; k++) begin
         rand_vin();
         rand_mask(m);
         c = '{sar10: 1'b1, smpl_sel: 2'(k), step_slow: k[0]};
         run_single(m, c);
      end

      for (int k = 0; k < 3; k++) begin
         rand_vin();
         rand_mask(m);
         c = '{sar10: 1'b0, smpl_sel: 2'(3 - k), step_slow: k[1]};
         run_single(m, c);
      end

      rand_vin();
      rand_mask(m);
      c = '{sar10: 1'b1, smpl_sel: 2'd1, step_slow: 1'b0};
      scan_mode = 1'b1;
      send_cmd(CMD_SCAN, m, c);
      wait_results(m, 2, 3 * CONV_MAX);
      assert (scanning === 1'b1) else begin
         fails++;
         $display("scan mode ended without a stop command");
      end
      stopping = 1'b1; // stop may cut a sampling window short
      send_cmd(CMD_STOP, m, c);
      @(negedge clk);
      assert (scanning === 1'b0 && busy === '0) else begin
         errors++;
         $display("ERROR after stop: scanning=%h exp 0, busy=%h exp 0", scanning, busy);
      end
      repeat (N_LANES + 2) @(negedge clk);
      quiet = 1'b1;
      repeat (20) @(negedge clk);
      quiet = 1'b0;

      $display("summary: %0d value errors, %0d other failures", errors, fails);
      if (errors == 0 && fails == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== test/tb_comp_model.sv ====
`timescale 1ns/1ps

module tb_comp_model import sar_pkg::*; #(
   parameter int N_LANES = 4
) (
   input  logic [N_LANES-1:0][CODE_W-1:0] vin,      // held input level per lane
   input  logic [N_LANES-1:0][CODE_W-1:0] dac_code,
   output logic [N_LANES-1:0]             comp
);

   // ideal comparator tripping at or above the DAC code
   always_comb begin
      for (int i = 0; i < N_LANES; i++) begin
         comp[i] = ((vin[i] >= dac_code[i]) === 1'b1); // unknown DAC reads low
      end
   end

endmodule

// ==== hdl/sar_adc_top.sv ====
`timescale 1ns/1ps

module sar_adc_top import sar_pkg::*; #(
   parameter int N_LANES = 4
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           cmd_stb,
   input  sar_cmd_e                       cmd,
   input  logic [N_LANES-1:0]             lane_mask,
   input  sar_cfg_t                       cfg,
   input  logic [N_LANES-1:0]             comp,
   output logic [N_LANES-1:0][CODE_W-1:0] dac_code,
   output logic [N_LANES-1:0]             sample,
   output logic [N_LANES-1:0]             busy,
   output logic                           scanning,
   output logic                           res_valid,
   output sar_result_t                    res
);

   logic [N_LANES-1:0]             start;
   logic [N_LANES-1:0]             lane_done;
   logic [N_LANES-1:0][CODE_W-1:0] lane_code;
   logic                           stop;
   sar_cfg_t                       cfg_q;   // shared by all lanes

   sar_sequencer #(.N_LANES(N_LANES)) u_seq (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_stb   (cmd_stb),
      .cmd       (cmd),
      .lane_mask (lane_mask),
      .cfg       (cfg),
      .lane_done (lane_done),
      .start     (start),
      .stop      (stop),
      .cfg_q     (cfg_q),
      .scanning  (scanning)
   );

   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      sar_lane u_lane (
         .clk      (clk),
         .rst_n    (rst_n),
         .cfg      (cfg_q),
         .start    (start[i]),
         .stop     (stop),
         .comp     (comp[i]),
         .busy     (busy[i]),
         .done     (lane_done[i]),
         .sample   (sample[i]),
         .dac_code (dac_code[i]),
         .code     (lane_code[i])
      );
   end

   sar_result_collect #(.N_LANES(N_LANES)) u_collect (
      .clk       (clk),
      .rst_n     (rst_n),
      .lane_done (lane_done),
      .lane_code (lane_code),
      .sar10     (cfg_q.sar10),
      .res_valid (res_valid),
      .res       (res)
   );

endmodule

// ==== hdl/sar_result_collect.sv ====
`timescale 1ns/1ps

module sar_result_collect import sar_pkg::*; #(
   parameter int N_LANES = 4
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [N_LANES-1:0]             lane_done,
   input  logic [N_LANES-1:0][CODE_W-1:0] lane_code,
   input  logic                           sar10,
   output logic                           res_valid,
   output sar_result_t                    res
);

   localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [N_LANES-1:0]             pend;    // finished, not yet emitted
   logic [N_LANES-1:0][CODE_W-1:0] code_q;
   logic [N_LANES-1:0]             s10_q;   // mode at done
   logic [N_LANES-1:0]             grant;
   logic [LANE_W-1:0]              gnt_idx;
   logic [LANE_W-1:0]              ptr;     // highest priority lane

   // scan from ptr upward so the lowest offset wins
   always_comb begin
      int unsigned sel;
      grant   = '0;
      gnt_idx = '0;
      for (int k = N_LANES - 1; k >= 0; k--) begin
         sel = (int'(ptr) + k) % N_LANES;
         if (pend[sel]) begin
            grant      = '0;
            grant[sel] = 1'b1;
            gnt_idx    = LANE_W'(sel);
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_LANES; i++) begin
         if (lane_done[i]) begin
            code_q[i] <= lane_code[i];
            s10_q[i]  <= sar10;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend      <= '0;
         ptr       <= '0;
         res_valid <= 1'b0;
      end else begin
         pend      <= (pend & ~grant) | lane_done;
         res_valid <= |grant;
         if (|grant) begin
            ptr <= (gnt_idx == LANE_W'(N_LANES - 1)) ? '0 : gnt_idx + 1'b1; // past winner
         end
      end
   end

   always_ff @(posedge clk) begin
      if (|grant) begin
         res.lane  <= RES_LANE_W'(gnt_idx);
         res.code  <= code_q[gnt_idx];
         res.sar10 <= s10_q[gnt_idx];
      end
   end

   a_grant_onehot: assert property (
      @(posedge clk) disable iff (!rst_n) $onehot0(grant)
   ) else $error("grant not one-hot, grant=%h", grant);

endmodule

// ==== hdl/sar_lane.sv ====
`timescale 1ns/1ps

module sar_lane import sar_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  sar_cfg_t          cfg,
   input  logic              start,
   input  logic              stop,
   input  logic              comp,
   output logic              busy,
   output logic              done,
   output logic              sample,   // hold switch
   output logic [CODE_W-1:0] dac_code,
   output logic [CODE_W-1:0] code
);

   lane_state_e       state;
   lane_state_e       state_nxt;
   logic              smpl_end;
   logic              step_end;
   logic              last_step;
   logic              init;
   logic              step;
   logic              finish;
   logic [CODE_W-1:0] report;

   assign busy   = (state != IDLE);
   assign init   = (state == SAMPLE) && smpl_end;
   assign step   = (state == CONVERT) && step_end;
   assign finish = step && last_step && !stop;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (start) state_nxt = SAMPLE;
         SAMPLE:  if (stop) state_nxt = IDLE; else if (smpl_end) state_nxt = CONVERT;
         CONVERT: if (stop || (step_end && last_step)) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= IDLE;
         sample <= 1'b0;
         done   <= 1'b0;
      end else begin
         state  <= state_nxt;
         sample <= (state_nxt == SAMPLE); // level, not decoded
         done   <= finish;
      end
   end

   always_ff @(posedge clk) begin
      if (finish) code <= report; // held until the next done
   end

   sar_cycle_timer u_timer (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .run       (busy),
      .stop      (stop),
      .smpl_end  (smpl_end),
      .step_end  (step_end),
      .last_step (last_step),
      .step_idx  ()
   );

   sar_search u_search (
      .clk      (clk),
      .rst_n    (rst_n),
      .init     (init),
      .step     (step),
      .comp     (comp),
      .dac_code (dac_code),
      .report   (report)
   );

endmodule

// ==== hdl/sar_search.sv ====
`timescale 1ns/1ps

module sar_search import sar_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              init,     // end of sampling
   input  logic              step,     // end of a compare step
   input  logic              comp,     // input above the midpoint
   output logic [CODE_W-1:0] dac_code,
   output logic [CODE_W-1:0] report
);

   logic [CODE_W-1:0] lo;
   logic [CODE_W-1:0] up;
   logic [CODE_W-1:0] mid;     // midpoint under test
   logic [CODE_W-1:0] rpt_lo;
   logic [CODE_W-1:0] rpt_up;
   logic [CODE_W-1:0] nxt_lo;
   logic [CODE_W-1:0] nxt_up;
   logic [CODE_W:0]   sum_cur;
   logic [CODE_W:0]   sum_rpt;
   logic [CODE_W:0]   sum_nxt;

   assign sum_cur = {1'b0, lo} + {1'b0, up};
   assign mid     = sum_cur[CODE_W:1];

   // bounds after the current comparison
   assign rpt_lo = comp ? mid : lo;
   assign rpt_up = comp ? up : mid; // chase downward
   assign nxt_lo = init ? '0 : rpt_lo;
   assign nxt_up = init ? '1 : rpt_up;

   assign sum_rpt = {1'b0, rpt_lo} + {1'b0, rpt_up};
   assign sum_nxt = {1'b0, nxt_lo} + {1'b0, nxt_up};

   // an even final midpoint means the search ended one below up,
   // so up is the code; otherwise the bounds still straddle it
   assign report = mid[0] ? sum_rpt[CODE_W:1] : rpt_up;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lo       <= '0;
         up       <= '1;
         dac_code <= '0;
      end else if (init || step) begin
         lo <= nxt_lo;
         up <= nxt_up;
         // comparator trips at or above its code, so drive one above the
         // midpoint and comp then reads as input strictly above mid
         dac_code <= sum_nxt[CODE_W:1] + CODE_W'(1);
      end
   end

   a_bounds_ordered: assert property (
      @(posedge clk) disable iff (!rst_n) (init || step) |=> (lo <= up)
   ) else $error("search bounds crossed, lo=%h up=%h", lo, up);

endmodule

// ==== hdl/sar_cycle_timer.sv ====
`timescale 1ns/1ps

module sar_cycle_timer import sar_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  sar_cfg_t   cfg,
   input  logic       run,       // lane busy
   input  logic       stop,
   output logic       smpl_end,
   output logic       step_end,
   output logic       last_step,
   output logic [3:0] step_idx
);

   logic [CNT_W-1:0] cyc_cnt;  // cycles within the current window
   logic [CNT_W-1:0] cyc_lim;
   logic [CNT_W-1:0] step_lim;
   logic             in_smpl;  // sampling window precedes step 0
   logic             cyc_done;

   assign step_lim = cfg.step_slow ? STEP_CYCLES_SLOW : STEP_CYCLES_FAST;
   assign cyc_lim  = in_smpl ? SMPL_CYCLES[cfg.smpl_sel] : step_lim;

   assign cyc_done  = run && (cyc_cnt == cyc_lim);
   assign smpl_end  = cyc_done && in_smpl;
   assign step_end  = cyc_done && !in_smpl;
   assign last_step = (step_idx == (cfg.sar10 ? 4'd9 : 4'd7));

   always_ff @(posedge clk) begin
      if (!rst_n || stop || !run || cyc_done) begin
         cyc_cnt <= '0;
      end else begin
         cyc_cnt <= cyc_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || stop || !run) begin
         step_idx <= '0;
         in_smpl  <= 1'b1;
      end else if (smpl_end) begin
         in_smpl <= 1'b0;
      end else if (step_end) begin
         if (last_step) begin
            step_idx <= '0; // back to sampling for the next run
            in_smpl  <= 1'b1;
         end else begin
            step_idx <= step_idx + 1'b1;
         end
      end
   end

   // trips if cfg.sar10 drops after step 7 of a running conversion
   a_step_range: assert property (
      @(posedge clk) disable iff (!rst_n) step_idx <= 4'd9
   ) else $error("step_idx out of range, step_idx=%h", step_idx);

endmodule

// ==== hdl/sar_sequencer.sv ====
`timescale 1ns/1ps

module sar_sequencer import sar_pkg::*; #(
   parameter int N_LANES = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cmd_stb,
   input  sar_cmd_e           cmd,
   input  logic [N_LANES-1:0] lane_mask,
   input  sar_cfg_t           cfg,
   input  logic [N_LANES-1:0] lane_done,
   output logic [N_LANES-1:0] start,
   output logic               stop,
   output sar_cfg_t           cfg_q,
   output logic               scanning
);

   logic [N_LANES-1:0] mask_q;    // lanes of the running command
   logic [N_LANES-1:0] active;    // lane started and not yet done
   logic [N_LANES-1:0] idle;
   logic [N_LANES-1:0] start_nxt;
   logic               is_stop;
   logic               is_go;

   assign idle    = ~active | lane_done; // a finishing lane counts as free
   assign is_stop = cmd_stb && (cmd == CMD_STOP);
   assign is_go   = cmd_stb && (cmd == CMD_SINGLE || cmd == CMD_SCAN);

   // new command wins over scan restarts; a stop suppresses both
   always_comb begin
      start_nxt = '0;
      if (is_go) begin
         start_nxt = lane_mask & idle;
      end else if (scanning && !is_stop) begin
         start_nxt = lane_done & mask_q; // restart from own done
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         start    <= '0;
         stop     <= 1'b0;
         scanning <= 1'b0;
         active   <= '0;
         mask_q   <= '0;
         cfg_q    <= '0;
      end else begin
         start <= start_nxt;
         stop  <= is_stop;
         if (is_stop) begin
            scanning <= 1'b0;
         end else if (is_go) begin
            scanning <= (cmd == CMD_SCAN);
         end
         if (is_stop) begin
            active <= '0; // lanes abort on stop
         end else begin
            active <= (active & ~lane_done) | start_nxt;
         end
         if (is_go) begin
            mask_q <= lane_mask;
            cfg_q  <= cfg;
         end
      end
   end

   a_no_start_with_stop: assert property (
      @(posedge clk) disable iff (!rst_n) stop |-> (start == '0)
   ) else $error("start pulsed in the stop cycle, start=%h", start);

endmodule

// ==== hdl/sar_pkg.sv ====
package sar_pkg;

   localparam int CODE_W     = 10;                // DAC and result code width
   localparam int CNT_W      = 7;                 // DAC cycle counter width
   localparam int MAX_LANES  = 4;
   localparam int RES_LANE_W = $clog2(MAX_LANES); // lane tag in the result

   // sampling length N gives a window of N+1 cycles
   localparam logic [3:0][CNT_W-1:0] SMPL_CYCLES = {7'd83, 7'd59, 7'd47, 7'd35};

   localparam logic [CNT_W-1:0] STEP_CYCLES_FAST = 7'd11; // settle + compare
   localparam logic [CNT_W-1:0] STEP_CYCLES_SLOW = 7'd23;

   typedef struct packed {
      logic       sar10;     // 10 steps when set, else 8
      logic [1:0] smpl_sel;  // index into SMPL_CYCLES
      logic       step_slow; // long DAC settle
   } sar_cfg_t;

   typedef struct packed {
      logic [RES_LANE_W-1:0] lane;
      logic [CODE_W-1:0]     code;
      logic                  sar10;
   } sar_result_t;

   typedef enum logic [1:0] {
      IDLE,
      SAMPLE,
      CONVERT
   } lane_state_e;

   typedef enum logic [1:0] {
      CMD_NONE,
      CMD_SINGLE,
      CMD_SCAN,
      CMD_STOP
   } sar_cmd_e;

endpackage
